//--- Bender.yml
package:
  name: jac_core

sources:
  - include_dirs:
      - .
    files:
      - num_pkg.sv
      - sched_pkg.sv
      - fx_mult.sv
      - mat_mult.sv
      - array_mult.sv
      - sched_regs.sv
      - sched_seq.sv
      - jac_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - jac_core_assert.sv
      - jac_core_tb.sv

//--- arith_macros.svh
/* arithmetic core widths and schedule reset values. */

`ifndef ARITH_MACROS_SVH
`define ARITH_MACROS_SVH

// element format, signed q10.16.
`define ELEM_W 27
`define FRAC_W 16
`define PROD_W 36 // sign-extended operand inside a multiply.

// schedule counter.
`define CNT_W 8

`define DEF_PERIOD 113
`define DEF_CLR0   28
`define DEF_CLR1   98
`define DEF_VEC_LO 90 // vector window, lo inclusive.
`define DEF_VEC_HI 99

`endif

//--- array_mult.sv
/* nine-lane elementwise fixed-point multiplier with a sticky mask of
   lanes that saturated. */

`timescale 1ns/1ps
`default_nettype none

`include "arith_macros.svh"

module array_mult (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          en,
	input  num_pkg::mat_t a,
	input  num_pkg::mat_t b,
	output num_pkg::mat_t res,
	output logic [8:0]    ovf
);

	logic [8:0] sat;
	logic [8:0] sticky_q;

	for (genvar l = 0; l < 9; l++) begin : g_lane
		fx_mult u_fx_mult (
			.clk   (clk),
			.rst_n (rst_n),
			.en    (en),
			.a     (a[l]),
			.b     (b[l]),
			.p     (res[l]),
			.sat   (sat[l])
		);
	end

	// history of saturated lanes, only reset clears it.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			sticky_q <= '0;
		else if (en)
			sticky_q <= sticky_q | sat;
	end

	assign ovf = sticky_q | sat; // bit shows with its result.

endmodule

`default_nettype wire

//--- fx_mult.sv
/* registered fixed-point multiply. shifts out the fraction, saturates
   back to element width and flags the saturation. */

`timescale 1ns/1ps
`default_nettype none

`include "arith_macros.svh"

module fx_mult (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           en,
	input  num_pkg::elem_t a,
	input  num_pkg::elem_t b,
	output num_pkg::elem_t p,
	output logic           sat
);

	logic signed [`PROD_W-1:0] a_x, b_x;
	num_pkg::prod_t prod, shifted;
	logic [2*`PROD_W-`ELEM_W:0] top; // bits that must all match the sign.
	logic ovf;
	num_pkg::elem_t clip;

	assign a_x = {{(`PROD_W-`ELEM_W){a[`ELEM_W-1]}}, a};
	assign b_x = {{(`PROD_W-`ELEM_W){b[`ELEM_W-1]}}, b};
	assign prod = a_x * b_x;
	assign shifted = prod >>> `FRAC_W;

	assign top = shifted[2*`PROD_W-1:`ELEM_W-1];
	assign ovf = !((&top) || !(|top));
	assign clip = shifted[2*`PROD_W-1] ? {1'b1, {(`ELEM_W-1){1'b0}}}
		: {1'b0, {(`ELEM_W-1){1'b1}}};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			p   <= '0;
			sat <= 1'b0;
		end else if (en) begin
			p   <= ovf ? clip : shifted[`ELEM_W-1:0];
			sat <= ovf;
		end
	end

endmodule

`default_nettype wire

//--- jac_core.sv
/* shared-multiplier arithmetic core: schedule registers and sequencer
   driving the matrix multiplier, beside the elementwise multiplier. */

`timescale 1ns/1ps
`default_nettype none

`include "arith_macros.svh"

module jac_core (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              en,
	input  logic              cfg_we,
	input  logic [2:0]        cfg_addr,
	input  logic [`CNT_W-1:0] cfg_wdata,
	input  num_pkg::mat_t     mat_a,
	input  num_pkg::mat_t     mat_b,
	input  num_pkg::mat_t     arr_a,
	input  num_pkg::mat_t     arr_b,
	output logic [`CNT_W-1:0] count,
	output sched_pkg::mode_e  mat_mode,
	output num_pkg::mat_res_u mat_res,
	output num_pkg::mat_t     arr_res,
	output logic [8:0]        arr_ovf
);

	logic [`CNT_W-1:0] period;
	logic [`CNT_W-1:0] clr0;
	logic [`CNT_W-1:0] clr1;
	logic [`CNT_W-1:0] vec_lo;
	logic [`CNT_W-1:0] vec_hi;
	logic mat_clr;

	sched_regs u_sched_regs (
		.clk    (clk),
		.rst_n  (rst_n),
		.we     (cfg_we),
		.addr   (cfg_addr),
		.wdata  (cfg_wdata),
		.period (period),
		.clr0   (clr0),
		.clr1   (clr1),
		.vec_lo (vec_lo),
		.vec_hi (vec_hi)
	);

	sched_seq u_sched_seq (
		.clk      (clk),
		.rst_n    (rst_n),
		.en       (en),
		.period   (period),
		.clr0     (clr0),
		.clr1     (clr1),
		.vec_lo   (vec_lo),
		.vec_hi   (vec_hi),
		.count    (count),
		.mat_clr  (mat_clr),
		.mat_mode (mat_mode)
	);

	mat_mult u_mat_mult (
		.clk   (clk),
		.rst_n (rst_n),
		.en    (en),
		.clr   (mat_clr),
		.mode  (mat_mode),
		.a     (mat_a),
		.b     (mat_b),
		.res   (mat_res)
	);

	// free-running lanes, no schedule.
	array_mult u_array_mult (
		.clk   (clk),
		.rst_n (rst_n),
		.en    (en),
		.a     (arr_a),
		.b     (arr_b),
		.res   (arr_res),
		.ovf   (arr_ovf)
	);

endmodule

`default_nettype wire

//--- jac_core_assert.sv
/* bound checks for the arithmetic core. shadow models of the schedule
   and both multipliers, compared on every clock. */

`timescale 1ns/1ps
`default_nettype none

`include "arith_macros.svh"

module jac_core_assert (
	input logic              clk,
	input logic              rst_n,
	input logic              en,
	input logic              cfg_we,
	input logic [2:0]        cfg_addr,
	input logic [`CNT_W-1:0] cfg_wdata,
	input num_pkg::mat_t     mat_a,
	input num_pkg::mat_t     mat_b,
	input num_pkg::mat_t     arr_a,
	input num_pkg::mat_t     arr_b,
	input logic [`CNT_W-1:0] count,
	input logic              mat_clr,
	input sched_pkg::mode_e  mat_mode,
	input num_pkg::mat_res_u mat_res,
	input num_pkg::mat_t     arr_res,
	input logic [8:0]        arr_ovf
);

	localparam longint ELEM_MAX = (longint'(1) <<< (`ELEM_W - 1)) - 1;
	localparam longint ELEM_MIN = -ELEM_MAX - 1;

	int err_count = 0;

	logic [`CNT_W-1:0] period_s, clr0_s, clr1_s, lo_s, hi_s;
	logic [`CNT_W-1:0] exp_count;
	logic exp_clr, kill_q;
	sched_pkg::mode_e exp_mode, mode_q;
	num_pkg::mat_t ma_q, mb_q, exp_arr, lane_p;
	logic [8:0] exp_ovf, lane_s;
	longint lane_raw [9];
	num_pkg::mat_res_u mat_exp, exp_res;

	function automatic longint clamp(input longint v);
		if (v > ELEM_MAX)
			return ELEM_MAX;
		if (v < ELEM_MIN)
			return ELEM_MIN;
		return v;
	endfunction

	// q16 product with the fraction shifted out.
	function automatic longint shr_prod(input longint x, input longint y);
		return (x * y) >>> `FRAC_W;
	endfunction

	assign exp_mode = (exp_count >= lo_s && exp_count < hi_s) ? sched_pkg::MODE_VEC
		: sched_pkg::MODE_MAT;

	always_comb begin
		for (int l = 0; l < 9; l++) begin
			lane_raw[l] = shr_prod(longint'(arr_a[l]), longint'(arr_b[l]));
			lane_p[l] = num_pkg::elem_t'(clamp(lane_raw[l]));
			lane_s[l] = clamp(lane_raw[l]) != lane_raw[l];
		end
	end

	// expected output of the item held in stage one.
	always_comb begin
		longint acc;
		mat_exp = '0;
		for (int r = 0; r < 3; r++) begin
			for (int c = 0; c < 3; c++) begin
				acc = 0;
				for (int k = 0; k < 3; k++)
					acc += clamp(shr_prod(longint'(ma_q[r*3+k]), longint'(mb_q[k*3+c])));
				if (mode_q == sched_pkg::MODE_MAT)
					mat_exp.mat[r*3+c] = num_pkg::elem_t'(clamp(acc));
				else if (c == 0)
					mat_exp.vec.col[r] = num_pkg::elem_t'(clamp(acc));
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// shadow state
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			period_s  <= `CNT_W'(`DEF_PERIOD);
			clr0_s    <= `CNT_W'(`DEF_CLR0);
			clr1_s    <= `CNT_W'(`DEF_CLR1);
			lo_s      <= `CNT_W'(`DEF_VEC_LO);
			hi_s      <= `CNT_W'(`DEF_VEC_HI);
			exp_count <= '0;
			exp_clr   <= 1'b0;
			kill_q    <= 1'b0;
			mode_q    <= sched_pkg::MODE_MAT;
			ma_q      <= '0;
			mb_q      <= '0;
			exp_res   <= '0;
			exp_arr   <= '0;
			exp_ovf   <= '0;
		end else begin
			if (cfg_we) begin
				case (cfg_addr)
					sched_pkg::REG_PERIOD: begin
						period_s <= (cfg_wdata == '0) ? `CNT_W'(1) : cfg_wdata;
					end
					sched_pkg::REG_CLR0:   clr0_s <= cfg_wdata;
					sched_pkg::REG_CLR1:   clr1_s <= cfg_wdata;
					sched_pkg::REG_VEC_LO: lo_s <= cfg_wdata;
					sched_pkg::REG_VEC_HI: hi_s <= cfg_wdata;
					default: ;
				endcase
			end
			if (en) begin
				exp_count <= (int'(exp_count) + 1 >= int'(period_s)) ? '0 : exp_count + 1'b1;
				exp_clr   <= (exp_count == clr0_s) || (exp_count == clr1_s);
				kill_q    <= exp_clr; // entering item is dropped.
				mode_q    <= exp_mode;
				ma_q      <= mat_a;
				mb_q      <= mat_b;
				exp_res   <= (exp_clr || kill_q) ? '0 : mat_exp;
				exp_arr   <= lane_p;
				exp_ovf   <= exp_ovf | lane_s;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////////////////////

	a_arr_res: assert property (@(posedge clk) disable iff (!rst_n) arr_res == exp_arr)
		else begin
			$error("arr_res differs from the elementwise model");
			err_count++;
		end
	a_arr_ovf: assert property (@(posedge clk) disable iff (!rst_n) arr_ovf == exp_ovf)
		else begin
			$error("arr_ovf differs from the sticky overflow model");
			err_count++;
		end
	a_ovf_sticky: assert property (@(posedge clk) disable iff (!rst_n)
		($past(arr_ovf) & ~arr_ovf) == '0)
		else begin
			$error("arr_ovf bit fell without reset");
			err_count++;
		end
	a_mat_res: assert property (@(posedge clk) disable iff (!rst_n) mat_res == exp_res)
		else begin
			$error("mat_res differs from the matrix model");
			err_count++;
		end
	a_count: assert property (@(posedge clk) disable iff (!rst_n) count == exp_count)
		else begin
			$error("count broke the wrap rule");
			err_count++;
		end
	a_mode: assert property (@(posedge clk) disable iff (!rst_n) mat_mode == exp_mode)
		else begin
			$error("mat_mode does not follow the vector window");
			err_count++;
		end
	a_clr: assert property (@(posedge clk) disable iff (!rst_n) mat_clr == exp_clr)
		else begin
			$error("mat_clr does not follow the clear points");
			err_count++;
		end
	a_clr_zero: assert property (@(posedge clk) disable iff (!rst_n)
		en && mat_clr |=> mat_res == '0)
		else begin
			$error("mat_res not zeroed after clear");
			err_count++;
		end
	a_hold: assert property (@(posedge clk) disable iff (!rst_n) !en |=>
		$stable(count) && $stable(mat_res) && $stable(arr_res) && $stable(arr_ovf))
		else begin
			$error("outputs moved with en low");
			err_count++;
		end
	a_reset: assert property (@(posedge clk) $rose(rst_n) |-> count == '0 && !mat_clr &&
		mat_res == '0 && arr_res == '0 && arr_ovf == '0)
		else begin
			$error("outputs not cleared by reset");
			err_count++;
		end

endmodule

`default_nettype wire

//--- jac_core_tb.sv
/* testbench for the arithmetic core. random operands under the default
   and a written schedule, checked by the bound assertions. */

`timescale 1ns/1ps
`default_nettype none

`include "arith_macros.svh"

module jac_core_tb;

	logic              clk;
	logic              rst_n;
	logic              en;
	logic              cfg_we;
	logic [2:0]        cfg_addr;
	logic [`CNT_W-1:0] cfg_wdata;
	num_pkg::mat_t     mat_a, mat_b, arr_a, arr_b;
	logic [`CNT_W-1:0] count;
	sched_pkg::mode_e  mat_mode;
	num_pkg::mat_res_u mat_res;
	num_pkg::mat_t     arr_res;
	logic [8:0]        arr_ovf;

	integer seed;
	int timeouts;
	int assert_errs;
	logic full_range; // operands may saturate.

	jac_core u_jac_core (.*);

	bind jac_core jac_core_assert u_assert (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic num_pkg::elem_t rand_elem(input logic wide);
		if (wide)
			return num_pkg::elem_t'($random(seed));
		return num_pkg::elem_t'($random(seed) % 1048576); // sums stay in range.
	endfunction

	// new operands and en every falling edge.
	always @(negedge clk) begin
		if (rst_n) begin
			en = ($random(seed) & 7) != 0;
			for (int i = 0; i < 9; i++) begin
				mat_a[i] = rand_elem(full_range);
				mat_b[i] = rand_elem(full_range);
				arr_a[i] = rand_elem(full_range);
				arr_b[i] = rand_elem(full_range);
			end
		end
	end

	task automatic write_reg(input sched_pkg::reg_addr_e addr, input logic [`CNT_W-1:0] data);
		cfg_we    = 1'b1;
		cfg_addr  = addr;
		cfg_wdata = data;
		@(negedge clk);
		cfg_we = 1'b0;
	endtask

	task automatic wait_count(input logic [`CNT_W-1:0] value, input int limit,
		input string what);
		int n;
		n = 0;
		while (count !== value && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (count !== value) begin
			$display("timeout waiting for %s", what);
			timeouts++;
		end
	endtask

	initial begin
		seed       = 67;
		timeouts   = 0;
		full_range = 1'b0;
		rst_n      = 1'b0;
		en         = 1'b0;
		cfg_we     = 1'b0;
		cfg_addr   = '0;
		cfg_wdata  = '0;
		mat_a      = '0;
		mat_b      = '0;
		arr_a      = '0;
		arr_b      = '0;
		repeat (4) @(negedge clk);
		rst_n <= 1'b1;

		////////////////////////////////////////////////////////////////////////
		// default schedule
		////////////////////////////////////////////////////////////////////////
		wait_count(8'd112, 300, "count to reach 112 under the default period");
		wait_count(8'd0, 20, "count to wrap under the default period");
		full_range <= 1'b1;
		wait_count(8'd99, 300, "count to leave the default vector window");
		full_range <= 1'b0;
		wait_count(8'd0, 60, "count to wrap a second time");

		////////////////////////////////////////////////////////////////////////
		// written schedule
		////////////////////////////////////////////////////////////////////////
		write_reg(sched_pkg::REG_PERIOD, 8'd20);
		write_reg(sched_pkg::REG_CLR0, 8'd3);
		write_reg(sched_pkg::REG_CLR1, 8'd12);
		write_reg(sched_pkg::REG_VEC_LO, 8'd8);
		write_reg(sched_pkg::REG_VEC_HI, 8'd11);
		repeat (4) begin
			wait_count(8'd19, 60, "count to reach 19 under period 20");
			wait_count(8'd0, 20, "count to wrap under period 20");
			full_range <= ~full_range;
		end

		write_reg(sched_pkg::REG_PERIOD, 8'd1);
		wait_count(8'd0, 20, "count to settle at zero under period 1");
		repeat (16) @(negedge clk);

		assert_errs = u_jac_core.u_assert.err_count;
		if (assert_errs != 0)
			$display("** Error u_jac_core.u_assert.err_count 0x%0h, expected 0x0", assert_errs);
		$display("assertion errors %0d, timeouts %0d", assert_errs, timeouts);
		if (assert_errs == 0 && timeouts == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- mat_mult.sv
/* two-stage 3x3 fixed-point matrix multiplier, matrix times matrix or
   matrix times vector (column zero), with a scheduled clear. */

`timescale 1ns/1ps
`default_nettype none

`include "arith_macros.svh"

module mat_mult (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                en,
	input  logic                clr,
	input  sched_pkg::mode_e    mode,
	input  num_pkg::mat_t       a,
	input  num_pkg::mat_t       b,
	output num_pkg::mat_res_u   res
);

	num_pkg::elem_t prod [3][3][3]; // [row][col][term].
	logic signed [`ELEM_W+1:0] sum [3][3];
	logic kill_q;
	sched_pkg::mode_e mode_q;
	num_pkg::mat_res_u res_d;

	// three-term sum back to element width.
	function automatic num_pkg::elem_t sat_sum(input logic signed [`ELEM_W+1:0] s);
		logic [2:0] top;
		top = s[`ELEM_W+1:`ELEM_W-1];
		if (top == 3'b000 || top == 3'b111) begin
			return s[`ELEM_W-1:0];
		end else if (s[`ELEM_W+1]) begin
			return {1'b1, {(`ELEM_W-1){1'b0}}};
		end
		return {1'b0, {(`ELEM_W-1){1'b1}}};
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// stage one, products
	////////////////////////////////////////////////////////////////////////////

	for (genvar i = 0; i < 3; i++) begin : g_row
		for (genvar j = 0; j < 3; j++) begin : g_col
			for (genvar k = 0; k < 3; k++) begin : g_term
				fx_mult u_fx_mult (
					.clk   (clk),
					.rst_n (rst_n),
					.en    (en),
					.a     (a[i*3+k]),
					.b     (b[k*3+j]),
					.p     (prod[i][j][k]),
					.sat   ()
				);
			end
			assign sum[i][j] = prod[i][j][0] + prod[i][j][1] + prod[i][j][2];
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stage two, sums
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		res_d = '0;
		if (mode_q == sched_pkg::MODE_VEC) begin
			for (int r = 0; r < 3; r++) begin
				res_d.vec.col[r] = sat_sum(sum[r][0]); // pad stays zero.
			end
		end else begin
			for (int r = 0; r < 3; r++) begin
				for (int c = 0; c < 3; c++) begin
					res_d.mat[r*3+c] = sat_sum(sum[r][c]);
				end
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			kill_q <= 1'b0;
			mode_q <= sched_pkg::MODE_MAT;
			res    <= '0;
		end else if (en) begin
			kill_q <= clr; // item entering now is dropped.
			mode_q <= mode;
			res    <= (clr || kill_q) ? '0 : res_d;
		end
	end

endmodule

`default_nettype wire

//--- num_pkg.sv
/* number formats of the arithmetic core: elements, products, matrices
   and the two views of a matrix result. */

`default_nettype none

`include "arith_macros.svh"

package num_pkg;

	typedef logic signed [`ELEM_W-1:0] elem_t;

	// full product of two sign-extended operands.
	typedef logic signed [2*`PROD_W-1:0] prod_t;

	// row-major, index is row*3 + col.
	typedef elem_t [8:0] mat_t;

	// vector view, pad sits above the three vector elements.
	typedef struct packed {
		elem_t [5:0] pad;
		elem_t [2:0] col;
	} vec_t;

	typedef union packed {
		mat_t mat;
		vec_t vec;
	} mat_res_u;

endpackage

`default_nettype wire

//--- sched_pkg.sv
/* schedule definitions: register map of the settings block and the
   matrix multiplier mode. */

`default_nettype none

`include "arith_macros.svh"

package sched_pkg;

	////////////////////////////////////////////////////////////////////////////
	// register map
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		REG_PERIOD = 3'd0,
		REG_CLR0   = 3'd1,
		REG_CLR1   = 3'd2,
		REG_VEC_LO = 3'd3,
		REG_VEC_HI = 3'd4
	} reg_addr_e;

	////////////////////////////////////////////////////////////////////////////
	// multiplier mode
	////////////////////////////////////////////////////////////////////////////

	// vector mode is the low encoding, as on the mat_mode pin.
	typedef enum logic {
		MODE_VEC = 1'b0,
		MODE_MAT = 1'b1
	} mode_e;

endpackage

`default_nettype wire

//--- sched_regs.sv
/* schedule settings: period, the two clear points and the vector
   window, written through a small address map. */

`timescale 1ns/1ps
`default_nettype none

`include "arith_macros.svh"

module sched_regs (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              we,
	input  logic [2:0]        addr,
	input  logic [`CNT_W-1:0] wdata,
	output logic [`CNT_W-1:0] period,
	output logic [`CNT_W-1:0] clr0,
	output logic [`CNT_W-1:0] clr1,
	output logic [`CNT_W-1:0] vec_lo,
	output logic [`CNT_W-1:0] vec_hi
);

	logic [`CNT_W-1:0] period_w;

	// zero period would leave the counter nowhere to wrap.
	assign period_w = (wdata == '0) ? `CNT_W'(1) : wdata;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			period <= `CNT_W'(`DEF_PERIOD);
			clr0   <= `CNT_W'(`DEF_CLR0);
			clr1   <= `CNT_W'(`DEF_CLR1);
			vec_lo <= `CNT_W'(`DEF_VEC_LO);
			vec_hi <= `CNT_W'(`DEF_VEC_HI);
		end else if (we) begin
			case (addr)
				sched_pkg::REG_PERIOD: begin
					period <= period_w;
				end
				sched_pkg::REG_CLR0: begin
					clr0 <= wdata;
				end
				sched_pkg::REG_CLR1: begin
					clr1 <= wdata;
				end
				sched_pkg::REG_VEC_LO: begin
					vec_lo <= wdata;
				end
				sched_pkg::REG_VEC_HI: begin
					vec_hi <= wdata;
				end
				default: begin
					// unmapped, write dropped.
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- sched_seq.sv
/* schedule sequencer. counts a repeating period and derives the matrix
   multiplier's clear pulse and mode from the count. */

`timescale 1ns/1ps
`default_nettype none

`include "arith_macros.svh"

module sched_seq (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              en,
	input  logic [`CNT_W-1:0] period,
	input  logic [`CNT_W-1:0] clr0,
	input  logic [`CNT_W-1:0] clr1,
	input  logic [`CNT_W-1:0] vec_lo,
	input  logic [`CNT_W-1:0] vec_hi,
	output logic [`CNT_W-1:0] count,
	output logic              mat_clr,
	output sched_pkg::mode_e  mat_mode
);

	logic [`CNT_W-1:0] last;
	logic wrap;
	logic clr_hit;

	assign last = period - 1'b1; // period is never zero.

	// also catches a period written below the running count.
	assign wrap = (count >= last);

	assign clr_hit = (count == clr0) || (count == clr1);

	////////////////////////////////////////////////////////////////////////////
	// counter and clear point
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count   <= '0;
			mat_clr <= 1'b0;
		end else if (en) begin
			count   <= wrap ? '0 : count + 1'b1;
			mat_clr <= clr_hit; // one enabled cycle late.
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// vector window
	////////////////////////////////////////////////////////////////////////////

	assign mat_mode = (count >= vec_lo && count < vec_hi) ? sched_pkg::MODE_VEC
		: sched_pkg::MODE_MAT;

endmodule

`default_nettype wire

//--- tb.f
+incdir+.
num_pkg.sv
sched_pkg.sv
fx_mult.sv
mat_mult.sv
array_mult.sv
sched_regs.sv
sched_seq.sv
jac_core.sv
jac_core_assert.sv
jac_core_tb.sv
